//--- Bender.yml
package:
  name: cpu_core

sources:
  - src/cpu_pkg.sv
  - src/fetch_stage.sv
  - src/pipe_control.sv
  - src/register_file.sv
  - src/execute_stage.sv
  - src/memory_stage.sv
  - src/cpu_core.sv
  - target: simulation
    files:
      - verif/tb_cpu_core.sv

//--- sim.f
src/cpu_pkg.sv
src/fetch_stage.sv
src/pipe_control.sv
src/register_file.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_core.sv
verif/tb_cpu_core.sv

//--- src/cpu_core.sv
module cpu_core import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       imem_we,
  input  imem_addr_t imem_addr,
  input  instr_t     imem_wdata,
  output wb_t        retire
);

  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  wb_t       wb;
  logic      stall;
  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  data_t     rs_data;
  data_t     rt_data;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;

  fetch_stage u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .stall      (stall),
    .if_id      (if_id)
  );

  pipe_control u_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .if_id   (if_id),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .ex_mem  (ex_mem),
    .wb      (wb),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .stall   (stall),
    .id_ex   (id_ex),
    .fwd_a   (fwd_a),
    .fwd_b   (fwd_b)
  );

  register_file u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .wb      (wb),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  execute_stage u_exec (
    .clk    (clk),
    .rst_n  (rst_n),
    .id_ex  (id_ex),
    .fwd_a  (fwd_a),
    .fwd_b  (fwd_b),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  memory_stage u_mem (
    .clk    (clk),
    .rst_n  (rst_n),
    .ex_mem (ex_mem),
    .wb     (wb)
  );

  // every register write leaves the core
  assign retire = wb;

endmodule

//--- src/cpu_pkg.sv
package cpu_pkg;

  ////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int DATA_WIDTH      = 32;
  localparam int INSTR_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH  = 5;
  localparam int NUM_REGS        = 32;
  localparam int IMM_WIDTH       = 16;
  localparam int IMEM_DEPTH      = 64;
  localparam int DMEM_DEPTH      = 64;
  localparam int IMEM_ADDR_WIDTH = 6;
  localparam int DMEM_ADDR_WIDTH = 6;

  // instruction fields
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;

  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [INSTR_WIDTH-1:0]     instr_t;
  typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;
  typedef logic [IMEM_ADDR_WIDTH-1:0] imem_addr_t;
  typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;

  // any code not listed behaves as a nop
  typedef enum logic [5:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_SLT  = 6'd5,
    OP_ADDI = 6'd8,
    OP_LW   = 6'd16,
    OP_SW   = 6'd17
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_REG,
    FWD_EX_MEM,
    FWD_WB
  } fwd_sel_e;

  ////////////////////////////////////////////////////////////
  // pipeline registers
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;
    logic    reg_dst;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
  } ctrl_t;

  typedef struct packed {
    logic   valid;
    instr_t instr;
  } if_id_t;

  typedef struct packed {
    logic                 valid;
    ctrl_t                ctrl;
    reg_addr_t            rs;
    reg_addr_t            rt;
    reg_addr_t            dest;
    data_t                rs_data;
    data_t                rt_data;
    logic [IMM_WIDTH-1:0] imm;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    reg_addr_t dest;
    data_t     alu_result;
    data_t     store_data;
  } ex_mem_t;

  // one register write
  typedef struct packed {
    logic      valid;
    reg_addr_t dest;
    data_t     data;
  } wb_t;

endpackage

//--- src/execute_stage.sv
module execute_stage import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  id_ex_t   id_ex,
  input  fwd_sel_e fwd_a,
  input  fwd_sel_e fwd_b,
  input  wb_t      wb,
  output ex_mem_t  ex_mem
);

  data_t op_a;
  data_t op_b_reg;
  data_t op_b;
  data_t alu_result;

  function automatic data_t fwd_mux(input fwd_sel_e sel, input data_t reg_val,
                                    input data_t ex_val, input data_t wb_val);
    case (sel)
      FWD_EX_MEM: return ex_val;
      FWD_WB:     return wb_val;
      default:    return reg_val;
    endcase
  endfunction

  assign op_a     = fwd_mux(fwd_a, id_ex.rs_data, ex_mem.alu_result, wb.data);
  assign op_b_reg = fwd_mux(fwd_b, id_ex.rt_data, ex_mem.alu_result, wb.data);
  // immediate is zero-extended
  assign op_b     = id_ex.ctrl.alu_src ? {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, id_ex.imm} : op_b_reg;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_result = op_a - op_b;
      ALU_AND: alu_result = op_a & op_b;
      ALU_OR:  alu_result = op_a | op_b;
      ALU_SLT: alu_result = {{(DATA_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = op_a + op_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid     <= 1'b0;
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.dest       <= id_ex.dest;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= op_b_reg;
    end
  end

  a_mem_op_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    id_ex.valid |-> !(id_ex.ctrl.mem_read && id_ex.ctrl.mem_write)
  ) else $error("load and store decoded together");

endmodule

//--- src/fetch_stage.sv
module fetch_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       imem_we,
  input  imem_addr_t imem_addr,
  input  instr_t     imem_wdata,
  input  logic       stall,
  output if_id_t     if_id
);

  instr_t     imem [IMEM_DEPTH];
  imem_addr_t pc;

  // program load only happens under reset
  always_ff @(posedge clk) begin
    if (!rst_n && imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  // pc wraps at the end of memory by width
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc          <= '0;
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      pc          <= pc + 1'b1;
      if_id.valid <= 1'b1;
      if_id.instr <= imem[pc];
    end
  end

  a_load_in_reset: assert property (
    @(posedge clk) rst_n |-> !imem_we
  ) else $error("instruction memory write outside reset");

endmodule

//--- src/memory_stage.sv
module memory_stage import cpu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  ex_mem_t ex_mem,
  output wb_t     wb
);

  data_t      dmem [DMEM_DEPTH];
  dmem_addr_t dmem_addr;

  // mem/wb register
  logic      mem_wb_valid;
  logic      mem_wb_load;
  reg_addr_t mem_wb_dest;
  data_t     mem_wb_alu;
  data_t     mem_wb_rdata;

  // word addressed
  assign dmem_addr = ex_mem.alu_result[DMEM_ADDR_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write) begin
      dmem[dmem_addr] <= ex_mem.store_data;
    end
    if (ex_mem.mem_read) begin
      mem_wb_rdata <= dmem[dmem_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb_valid <= 1'b0;
      mem_wb_load  <= 1'b0;
    end else begin
      mem_wb_valid <= ex_mem.valid && ex_mem.reg_write;
      mem_wb_load  <= ex_mem.mem_read;
      mem_wb_dest  <= ex_mem.dest;
      mem_wb_alu   <= ex_mem.alu_result;
    end
  end

  always_comb begin
    wb.valid = mem_wb_valid;
    wb.dest  = mem_wb_dest;
    wb.data  = mem_wb_load ? mem_wb_rdata : mem_wb_alu;
  end

endmodule

//--- src/pipe_control.sv
module pipe_control import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  if_id_t    if_id,
  input  data_t     rs_data,
  input  data_t     rt_data,
  input  ex_mem_t   ex_mem,
  input  wb_t       wb,
  output reg_addr_t rs_addr,
  output reg_addr_t rt_addr,
  output logic      stall,
  output id_ex_t    id_ex,
  output fwd_sel_e  fwd_a,
  output fwd_sel_e  fwd_b
);

  opcode_e   opcode;
  reg_addr_t rd;
  reg_addr_t dest;
  ctrl_t     ctrl;
  logic      uses_rs;
  logic      uses_rt;
  logic      load_hit;

  assign opcode  = opcode_e'(if_id.instr[OPCODE_MSB:OPCODE_LSB]);
  assign rs_addr = if_id.instr[RS_MSB:RS_LSB];
  assign rt_addr = if_id.instr[RT_MSB:RT_LSB];
  assign rd      = if_id.instr[RD_MSB:RD_LSB];

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl    = '0;
    uses_rs = 1'b0;
    uses_rt = 1'b0;
    case (opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLT: begin
        ctrl.reg_dst   = 1'b1;
        ctrl.reg_write = 1'b1;
        uses_rs        = 1'b1;
        uses_rt        = 1'b1;
        case (opcode)
          OP_SUB:  ctrl.alu_op = ALU_SUB;
          OP_AND:  ctrl.alu_op = ALU_AND;
          OP_OR:   ctrl.alu_op = ALU_OR;
          OP_SLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl.alu_op = ALU_ADD;
        endcase
      end
      OP_ADDI: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        uses_rs        = 1'b1;
      end
      OP_LW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        uses_rs        = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        uses_rs        = 1'b1;
        uses_rt        = 1'b1;
      end
      default: ;
    endcase
    dest = ctrl.reg_dst ? rd : rt_addr;
    // r0 is never written, so later stages need no check
    if (dest == '0) begin
      ctrl.reg_write = 1'b0;
    end
  end

  // load-use hazard on the instruction in decode
  assign load_hit = id_ex.valid && id_ex.ctrl.mem_read && id_ex.ctrl.reg_write &&
                    ((uses_rs && id_ex.dest == rs_addr) ||
                     (uses_rt && id_ex.dest == rt_addr));
  assign stall = if_id.valid && load_hit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
      id_ex.ctrl  <= '0;
    end else begin
      id_ex.valid   <= if_id.valid && !stall;
      id_ex.ctrl    <= (if_id.valid && !stall) ? ctrl : '0;
      id_ex.rs      <= rs_addr;
      id_ex.rt      <= rt_addr;
      id_ex.dest    <= dest;
      id_ex.rs_data <= rs_data;
      id_ex.rt_data <= rt_data;
      id_ex.imm     <= if_id.instr[IMM_WIDTH-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // forwarding
  ////////////////////////////////////////////////////////////

  // loads in ex_mem have no result yet
  function automatic fwd_sel_e pick_fwd(input reg_addr_t src);
    if (ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read && ex_mem.dest == src) begin
      return FWD_EX_MEM;
    end
    if (wb.valid && wb.dest == src) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  always_comb begin
    fwd_a = pick_fwd(id_ex.rs);
    fwd_b = pick_fwd(id_ex.rt);
  end

  // the bubble behind a load never matches again
  a_single_stall: assert property (
    @(posedge clk) disable iff (!rst_n) stall |=> !stall
  ) else $error("stall held for two cycles");

endmodule

//--- src/register_file.sv
module register_file import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs_addr,
  input  reg_addr_t rt_addr,
  input  wb_t       wb,
  output data_t     rs_data,
  output data_t     rt_data
);

  data_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid) begin
      regs[wb.dest] <= wb.data;
    end
  end

  // write-through covers the distance 3 dependency
  assign rs_data = (wb.valid && wb.dest == rs_addr) ? wb.data : regs[rs_addr];
  assign rt_data = (wb.valid && wb.dest == rt_addr) ? wb.data : regs[rt_addr];

endmodule

//--- verif/tb_cpu_core.sv
module tb_cpu_core import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RETIRE_TIMEOUT = 20;

  logic       clk;
  logic       rst_n;
  logic       imem_we;
  imem_addr_t imem_addr;
  instr_t     imem_wdata;
  wb_t        retire;

  instr_t prog [$];
  wb_t    exp_q [$];
  data_t  model_regs [NUM_REGS];
  data_t  model_mem [DMEM_DEPTH];
  int     seed = 32'h5fa2_ff89;
  int     error_count = 0;
  int     check_count = 0;

  cpu_core u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_we    (imem_we),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .retire     (retire)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // instruction encoding
  ////////////////////////////////////////////////////////////

  function automatic instr_t r_format(input logic [5:0] op, input reg_addr_t rd,
                                      input reg_addr_t rs, input reg_addr_t rt);
    instr_t ins;
    ins = '0;
    ins[OPCODE_MSB:OPCODE_LSB] = op;
    ins[RS_MSB:RS_LSB]         = rs;
    ins[RT_MSB:RT_LSB]         = rt;
    ins[RD_MSB:RD_LSB]         = rd;
    return ins;
  endfunction

  function automatic instr_t i_format(input logic [5:0] op, input reg_addr_t rt,
                                      input reg_addr_t rs, input logic [IMM_WIDTH-1:0] imm);
    instr_t ins;
    ins = '0;
    ins[OPCODE_MSB:OPCODE_LSB] = op;
    ins[RS_MSB:RS_LSB]         = rs;
    ins[RT_MSB:RT_LSB]         = rt;
    ins[IMM_WIDTH-1:0]         = imm;
    return ins;
  endfunction

  function automatic reg_addr_t random_reg();
    return reg_addr_t'(1 + {$random(seed)} % 7);
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model, in program order
  ////////////////////////////////////////////////////////////

  task automatic expect_write(input reg_addr_t dest, input data_t value);
    wb_t item;
    // r0 stays zero and never retires
    if (dest != '0) begin
      model_regs[dest] = value;
      item.valid = 1'b1;
      item.dest  = dest;
      item.data  = value;
      exp_q.push_back(item);
    end
  endtask

  task automatic run_model();
    instr_t     ins;
    logic [5:0] op;
    data_t      a;
    data_t      b;
    data_t      imm32;
    dmem_addr_t addr;
    exp_q.delete();
    for (int r = 0; r < NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    foreach (prog[i]) begin
      ins   = prog[i];
      op    = ins[OPCODE_MSB:OPCODE_LSB];
      a     = model_regs[ins[RS_MSB:RS_LSB]];
      b     = model_regs[ins[RT_MSB:RT_LSB]];
      imm32 = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, ins[IMM_WIDTH-1:0]};
      addr  = dmem_addr_t'(a + imm32);
      case (op)
        OP_ADD:  expect_write(ins[RD_MSB:RD_LSB], a + b);
        OP_SUB:  expect_write(ins[RD_MSB:RD_LSB], a - b);
        OP_AND:  expect_write(ins[RD_MSB:RD_LSB], a & b);
        OP_OR:   expect_write(ins[RD_MSB:RD_LSB], a | b);
        OP_SLT:  expect_write(ins[RD_MSB:RD_LSB], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        OP_ADDI: expect_write(ins[RT_MSB:RT_LSB], a + imm32);
        OP_LW:   expect_write(ins[RT_MSB:RT_LSB], model_mem[addr]);
        OP_SW:   model_mem[addr] = b;
        default: ;
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////
  // program load, retire collection and checks
  ////////////////////////////////////////////////////////////

  task automatic load_program();
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      imem_we    = 1'b1;
      imem_addr  = imem_addr_t'(i);
      imem_wdata = (i < prog.size()) ? prog[i] : '0;
      @(negedge clk);
    end
    imem_we = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic check_wb(input wb_t exp, input wb_t got);
    check_count++;
    if (got.dest !== exp.dest || got.data !== exp.data) begin
      error_count++;
      $display("Fail retire: expected dest %h data %h, got dest %h data %h",
               exp.dest, exp.data, got.dest, got.data);
    end
  endtask

  // retire is stable at the falling edge
  task automatic collect_retires(input int quiet_cycles, output int checked);
    int waited;
    checked = 0;
    while (checked < exp_q.size()) begin
      waited = 0;
      @(negedge clk);
      while (!retire.valid && waited < RETIRE_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (!retire.valid) begin
        error_count++;
        $display("timeout: retire %0d of %0d never came", checked + 1, exp_q.size());
        break;
      end
      check_wb(exp_q[checked], retire);
      checked++;
    end
    // window ends before the pc wraps back into the program
    for (int i = 0; i < quiet_cycles; i++) begin
      @(negedge clk);
      if (retire.valid) begin
        error_count++;
        $display("unexpected extra retire to r%0d with data %h", retire.dest, retire.data);
      end
    end
  endtask

  task automatic run_test(input string name, input int quiet_cycles);
    int errors_before;
    int checked;
    errors_before = error_count;
    load_program();
    run_model();
    collect_retires(quiet_cycles, checked);
    $display("%-16s %0d retires checked, %0d errors", name, checked,
             error_count - errors_before);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic independent_alu();
    prog.delete();
    prog.push_back(i_format(OP_ADDI, 5'd1, 5'd0, 16'd12));
    // 0xffff must not sign extend
    prog.push_back(i_format(OP_ADDI, 5'd2, 5'd0, 16'hffff));
    prog.push_back(i_format(OP_ADDI, 5'd3, 5'd0, 16'd5));
    repeat (3) prog.push_back('0);
    prog.push_back(r_format(OP_SUB, 5'd4, 5'd0, 5'd3));
    repeat (3) prog.push_back('0);
    prog.push_back(r_format(OP_ADD, 5'd5, 5'd1, 5'd2));
    prog.push_back(r_format(OP_SUB, 5'd6, 5'd1, 5'd3));
    prog.push_back(r_format(OP_AND, 5'd7, 5'd2, 5'd1));
    prog.push_back(r_format(OP_OR, 5'd8, 5'd1, 5'd3));
    prog.push_back(r_format(OP_SLT, 5'd9, 5'd4, 5'd1));
    prog.push_back(r_format(OP_SLT, 5'd10, 5'd1, 5'd4));
    prog.push_back(r_format(OP_SLT, 5'd11, 5'd2, 5'd4));
    run_test("independent_alu", 8);
  endtask

  task automatic dependent_chains();
    prog.delete();
    prog.push_back(i_format(OP_ADDI, 5'd1, 5'd0, 16'd3));
    prog.push_back(i_format(OP_ADDI, 5'd2, 5'd1, 16'd4));
    prog.push_back(r_format(OP_ADD, 5'd3, 5'd1, 5'd2));
    prog.push_back(r_format(OP_ADD, 5'd4, 5'd1, 5'd3));
    prog.push_back(r_format(OP_SUB, 5'd5, 5'd4, 5'd2));
    prog.push_back(r_format(OP_OR, 5'd6, 5'd5, 5'd3));
    prog.push_back(r_format(OP_AND, 5'd7, 5'd6, 5'd6));
    // newest producer must win over the older one
    prog.push_back(i_format(OP_ADDI, 5'd8, 5'd0, 16'd1));
    prog.push_back(i_format(OP_ADDI, 5'd8, 5'd8, 16'd2));
    prog.push_back(i_format(OP_ADDI, 5'd8, 5'd8, 16'd4));
    prog.push_back(r_format(OP_ADD, 5'd9, 5'd8, 5'd8));
    run_test("dependent_chains", 8);
  endtask

  task automatic store_load();
    prog.delete();
    prog.push_back(i_format(OP_ADDI, 5'd1, 5'd0, 16'h1234));
    prog.push_back(i_format(OP_ADDI, 5'd2, 5'd0, 16'd9));
    prog.push_back(i_format(OP_SW, 5'd1, 5'd2, 16'd0));
    prog.push_back(i_format(OP_LW, 5'd3, 5'd2, 16'd0));
    prog.push_back(r_format(OP_ADD, 5'd4, 5'd3, 5'd3));
    prog.push_back(i_format(OP_ADDI, 5'd5, 5'd0, 16'd3));
    prog.push_back(i_format(OP_SW, 5'd4, 5'd5, 16'd7));
    prog.push_back(i_format(OP_LW, 5'd6, 5'd0, 16'd10));
    // store data comes straight from a load
    prog.push_back(i_format(OP_SW, 5'd6, 5'd0, 16'd11));
    prog.push_back(i_format(OP_LW, 5'd7, 5'd0, 16'd11));
    prog.push_back(r_format(OP_SUB, 5'd8, 5'd7, 5'd1));
    run_test("store_load", 8);
  endtask

  task automatic zero_register();
    prog.delete();
    prog.push_back(i_format(OP_ADDI, 5'd0, 5'd0, 16'd77));
    prog.push_back(i_format(OP_ADDI, 5'd1, 5'd0, 16'd5));
    prog.push_back(r_format(OP_ADD, 5'd0, 5'd1, 5'd1));
    prog.push_back(r_format(OP_ADD, 5'd2, 5'd0, 5'd1));
    prog.push_back(i_format(OP_ADDI, 5'd3, 5'd0, 16'd1));
    run_test("zero_register", 8);
  endtask

  task automatic nop_and_unknown();
    prog.delete();
    prog.push_back(i_format(OP_ADDI, 5'd1, 5'd0, 16'd1));
    // nop with live register fields
    prog.push_back(r_format(OP_NOP, 5'd4, 5'd1, 5'd4));
    prog.push_back(r_format(6'd63, 5'd3, 5'd1, 5'd2));
    prog.push_back(i_format(6'd9, 5'd2, 5'd1, 16'h00ff));
    prog.push_back(i_format(OP_ADDI, 5'd2, 5'd1, 16'd1));
    run_test("nop_and_unknown", 40);
  endtask

  task automatic random_alu();
    int         pick;
    logic [5:0] op;
    reg_addr_t  rd;
    prog.delete();
    for (int r = 1; r < 8; r++) begin
      prog.push_back(i_format(OP_ADDI, reg_addr_t'(r), 5'd0, 16'($random(seed))));
    end
    for (int n = 0; n < 30; n++) begin
      pick = {$random(seed)} % 6;
      rd   = random_reg();
      case (pick)
        0:       op = OP_ADD;
        1:       op = OP_SUB;
        2:       op = OP_AND;
        3:       op = OP_OR;
        4:       op = OP_SLT;
        default: op = OP_ADDI;
      endcase
      if (op == OP_ADDI) begin
        prog.push_back(i_format(op, rd, random_reg(), 16'($random(seed))));
      end else begin
        prog.push_back(r_format(op, rd, random_reg(), random_reg()));
      end
    end
    run_test("random_alu", 8);
  endtask

  initial begin
    rst_n      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    independent_alu();
    dependent_chains();
    store_load();
    zero_register();
    nop_and_unknown();
    random_alu();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
